//--- include/ringbuf_defs.svh
`ifndef RINGBUF_DEFS_SVH
`define RINGBUF_DEFS_SVH

// Ring memory geometry
`define RING_ADDR_W       12
`define RING_DEPTH        4096
`define RING_WORD_W       18

// Sample word fields
`define SAMPLE_W          12
`define OVLP_CNT_W        4

// L1A fields
`define L1A_CNT_W         24
`define L1A_MCNT_W        12

// L1A FIFO, 32 entries
`define L1A_FIFO_AW       5
`define L1A_FIFO_DEPTH    32

// Samples per event
`define SAMP_CNT_W        7

// Words the writer must lead the reader by before a read
`define RING_AMT_LEVEL    7

// Occupancy past the oldest pending start address that raises the warning
`define RING_WARN_LEVEL   3328

`endif

//--- verilog/ring_data_pkg.sv
`default_nettype none

`include "ringbuf_defs.svh"

package ring_data_pkg;

	typedef logic [`SAMPLE_W-1:0]    sample_t;
	typedef logic [`OVLP_CNT_W-1:0]  ovlp_cnt_t;

	// {multi-overlap, overlap, overlap count, sample}
	typedef logic [`RING_WORD_W-1:0] ring_word_t;
	typedef logic [`RING_ADDR_W-1:0] ring_addr_t;

	typedef logic [`L1A_CNT_W-1:0]   l1a_cnt_t;
	typedef logic [`L1A_MCNT_W-1:0]  l1a_mcnt_t;

	// {phase, start address, match count, L1A number}
	typedef logic [1+`RING_ADDR_W+`L1A_MCNT_W+`L1A_CNT_W-1:0] l1a_entry_t;

	// {phase, match count, L1A number}
	typedef logic [1+`L1A_MCNT_W+`L1A_CNT_W-1:0] evt_hdr_t;

endpackage

`default_nettype wire

//--- verilog/readout_ctrl_pkg.sv
`default_nettype none

`include "ringbuf_defs.svh"

package readout_ctrl_pkg;

	typedef logic [`SAMP_CNT_W-1:0] samp_cnt_t;

	// One extra bit so a full FIFO can be counted
	typedef logic [`L1A_FIFO_AW:0] fifo_lvl_t;

	typedef enum logic [1:0] {
		TS_IDLE = 2'd0,
		TS_LOAD = 2'd1,
		TS_READ = 2'd2,
		TS_DONE = 2'd3
	} trans_state_t;

endpackage

`default_nettype wire

//--- verilog/l1a_fifo.sv
`default_nettype none

`include "ringbuf_defs.svh"

module l1a_fifo (
	input  wire                       CLK,
	input  wire                       RST_RESYNC,
	input  wire                       fifo_rst_i,
	input  wire                       push_i,
	input  wire                       pop_i,
	input  ring_data_pkg::l1a_entry_t entry_i,
	output ring_data_pkg::l1a_entry_t entry_o,
	output logic                      empty_o,
	output logic                      full_o,
	output readout_ctrl_pkg::fifo_lvl_t level_o
);

	import ring_data_pkg::*;
	import readout_ctrl_pkg::*;

	l1a_entry_t mem [0:`L1A_FIFO_DEPTH-1];

	logic [`L1A_FIFO_AW-1:0] wr_ptr;
	logic [`L1A_FIFO_AW-1:0] rd_ptr;
	fifo_lvl_t               count;
	logic                    wr_en;
	logic                    rd_en;

	assign wr_en = push_i & ~full_o;    // Push into full FIFO is dropped
	assign rd_en = pop_i & ~empty_o;

	assign empty_o = (count == '0);
	assign full_o  = (count == fifo_lvl_t'(`L1A_FIFO_DEPTH));
	assign level_o = count;

	// Show-ahead head entry
	assign entry_o = mem[rd_ptr];

	always_ff @(posedge CLK) begin
		if (wr_en) begin
			mem[wr_ptr] <= entry_i;
		end
	end

	always_ff @(posedge CLK or posedge RST_RESYNC) begin
		if (RST_RESYNC) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else if (fifo_rst_i) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (wr_en) begin
				wr_ptr <= wr_ptr + 1'b1;    // Wraps at 32
			end
			if (rd_en) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			if (wr_en && !rd_en) begin
				count <= count + 1'b1;
			end else if (rd_en && !wr_en) begin
				count <= count - 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

//--- verilog/sample_ring.sv
`default_nettype none

`include "ringbuf_defs.svh"

module sample_ring (
	input  wire                       CLK,
	input  wire                       RST_RESYNC,
	input  wire                       wren_i,
	input  ring_data_pkg::ring_word_t wr_word_i,
	input  wire                       ld_addr_i,
	input  ring_data_pkg::ring_addr_t strt_addr_i,
	input  wire                       nxt_wrd_i,
	input  wire                       pending_i,
	output ring_data_pkg::ring_addr_t wr_addr_o,
	output logic                      ring_amt_o,
	output ring_data_pkg::ring_word_t rd_word_o,
	output logic                      data_push_o,
	output logic                      warn_o
);

	import ring_data_pkg::*;

	ring_word_t mem [0:`RING_DEPTH-1];

	ring_addr_t wr_addr;
	ring_addr_t rd_addr;
	ring_addr_t rd_lead;
	ring_addr_t strt_lead;
	ring_word_t rd_q;
	logic       valid1;

	// Differences wrap modulo the ring depth
	assign rd_lead   = wr_addr - rd_addr;
	assign strt_lead = wr_addr - strt_addr_i;

	assign ring_amt_o = (rd_lead < ring_addr_t'(`RING_AMT_LEVEL));    // Not enough lead yet
	assign wr_addr_o  = wr_addr;

	always_ff @(posedge CLK) begin
		if (wren_i) begin
			mem[wr_addr] <= wr_word_i;
		end
	end

	// Two read stages so rd_word_o lines up with data_push_o
	always_ff @(posedge CLK) begin
		if (nxt_wrd_i) begin
			rd_q <= mem[rd_addr];
		end
		rd_word_o <= rd_q;
	end

	always_ff @(posedge CLK or posedge RST_RESYNC) begin
		if (RST_RESYNC) begin
			wr_addr <= '0;
		end else if (wren_i) begin
			wr_addr <= wr_addr + 1'b1;    // 4095 wraps to 0
		end
	end

	always_ff @(posedge CLK or posedge RST_RESYNC) begin
		if (RST_RESYNC) begin
			rd_addr <= '0;
		end else if (ld_addr_i) begin
			rd_addr <= strt_addr_i;    // Start of next event
		end else if (nxt_wrd_i) begin
			rd_addr <= rd_addr + 1'b1;
		end
	end

	always_ff @(posedge CLK or posedge RST_RESYNC) begin
		if (RST_RESYNC) begin
			valid1      <= 1'b0;
			data_push_o <= 1'b0;
		end else begin
			valid1      <= nxt_wrd_i;
			data_push_o <= valid1;
		end
	end

	// Writer getting close to overrunning the oldest pending event
	always_ff @(posedge CLK or posedge RST_RESYNC) begin
		if (RST_RESYNC) begin
			warn_o <= 1'b0;
		end else begin
			warn_o <= pending_i && (strt_lead > ring_addr_t'(`RING_WARN_LEVEL));
		end
	end

endmodule

`default_nettype wire

//--- verilog/ring_trans_fsm.sv
`default_nettype none

module ring_trans_fsm (
	input  wire                         CLK,
	input  wire                         RST_RESYNC,
	input  wire                         l1a_buf_mt_i,
	input  wire                         evt_buf_afl_i,
	input  wire                         ring_amt_i,
	input  readout_ctrl_pkg::samp_cnt_t samp_max_i,
	output logic                        ld_addr_o,
	output logic                        nxt_wrd_o
);

	import readout_ctrl_pkg::*;

	trans_state_t state;
	trans_state_t nxt_state;
	samp_cnt_t    wrd_cnt;
	logic         last_wrd;
	logic         done_cnt;

	assign last_wrd = (wrd_cnt == samp_cnt_t'(samp_max_i - 1'b1));

	// Header pulse and FIFO pop, held off by almost full
	assign ld_addr_o = (state == TS_LOAD) && !l1a_buf_mt_i && !evt_buf_afl_i;

	assign nxt_wrd_o = (state == TS_READ) && !ring_amt_i && !evt_buf_afl_i;

	always_comb begin
		nxt_state = state;
		case (state)
			TS_IDLE: begin
				if (!l1a_buf_mt_i && !evt_buf_afl_i) begin
					nxt_state = TS_LOAD;
				end
			end
			TS_LOAD: begin
				if (l1a_buf_mt_i) begin
					nxt_state = TS_IDLE;    // FIFO cleared under us
				end else if (!evt_buf_afl_i) begin
					if (samp_max_i == '0) begin
						nxt_state = TS_DONE;
					end else begin
						nxt_state = TS_READ;
					end
				end
			end
			TS_READ: begin
				if (nxt_wrd_o && last_wrd) begin
					nxt_state = TS_DONE;
				end
			end
			TS_DONE: begin
				if (done_cnt) begin
					nxt_state = TS_IDLE;    // Last word has left the ring pipeline
				end
			end
			default: begin
				nxt_state = TS_IDLE;
			end
		endcase
	end

	always_ff @(posedge CLK or posedge RST_RESYNC) begin
		if (RST_RESYNC) begin
			state <= TS_IDLE;
		end else begin
			state <= nxt_state;
		end
	end

	always_ff @(posedge CLK or posedge RST_RESYNC) begin
		if (RST_RESYNC) begin
			wrd_cnt <= '0;
		end else if (ld_addr_o) begin
			wrd_cnt <= '0;
		end else if (nxt_wrd_o) begin
			wrd_cnt <= wrd_cnt + 1'b1;
		end
	end

	// Two cycles in TS_DONE
	always_ff @(posedge CLK or posedge RST_RESYNC) begin
		if (RST_RESYNC) begin
			done_cnt <= 1'b0;
		end else if (state == TS_DONE) begin
			done_cnt <= ~done_cnt;
		end else begin
			done_cnt <= 1'b0;
		end
	end

endmodule

`default_nettype wire

//--- verilog/ringbuf_top.sv
`default_nettype none

module ringbuf_top (
	input  wire                         CLK,
	input  wire                         RST_RESYNC,
	input  wire                         fifo_rst_i,
	input  readout_ctrl_pkg::samp_cnt_t samp_max_i,
	input  ring_data_pkg::sample_t      wdata_i,
	input  wire                         wren_i,
	input  wire [37:0]                  l1a_smp_data_i,
	input  wire [6:0]                   ovrlp_smp_data_i,
	input  wire                         l1a_wrt_en_i,
	input  wire                         evt_buf_afl_i,
	output ring_data_pkg::evt_hdr_t     l1a_evt_data_o,
	output logic                        l1a_evt_push_o,
	output ring_data_pkg::ring_word_t   rdata_o,
	output logic                        data_push_o,
	output logic                        warn_o
);

	import ring_data_pkg::*;
	import readout_ctrl_pkg::*;

	// L1A sample fields
	l1a_cnt_t   l1acnt;
	l1a_mcnt_t  l1amcnt;
	logic       l1a_match_smp;
	logic       l1a_phase_smp;

	// Overlap fields
	ovlp_cnt_t  ovrlap_cnt;
	logic       ovrlap_smp;
	logic       multi_ovlp_smp;

	// FIFO head
	l1a_entry_t head;
	l1a_cnt_t   l1anum;
	l1a_mcnt_t  l1a_mtch_num;
	ring_addr_t strt_addr;
	logic       l1a_phs;

	l1a_entry_t new_entry;
	ring_word_t wr_word;
	ring_addr_t wr_addr;
	fifo_lvl_t  l1a_lvl;
	logic       l1a_push;
	logic       l1a_buf_mt;
	logic       ring_amt;
	logic       ld_addr;
	logic       nxt_wrd;

	assign {l1a_phase_smp, l1a_match_smp, l1amcnt, l1acnt} = l1a_smp_data_i;
	// Bit 6 is event end, not needed here
	assign {multi_ovlp_smp, ovrlap_smp, ovrlap_cnt} = ovrlp_smp_data_i[5:0];

	assign l1a_push  = l1a_wrt_en_i & l1a_match_smp;
	assign new_entry = {l1a_phase_smp, wr_addr, l1amcnt, l1acnt};    // Start at current write address
	assign wr_word   = {multi_ovlp_smp, ovrlap_smp, ovrlap_cnt, wdata_i};

	assign {l1a_phs, strt_addr, l1a_mtch_num, l1anum} = head;

	assign l1a_evt_data_o = {l1a_phs, l1a_mtch_num, l1anum};
	assign l1a_evt_push_o = ld_addr;

	l1a_fifo l1a_fifo_i (
		.CLK        (CLK),
		.RST_RESYNC (RST_RESYNC),
		.fifo_rst_i (fifo_rst_i),
		.push_i     (l1a_push),
		.pop_i      (ld_addr),
		.entry_i    (new_entry),
		.entry_o    (head),
		.empty_o    (l1a_buf_mt),
		.full_o     (),
		.level_o    (l1a_lvl)
	);

	sample_ring sample_ring_i (
		.CLK         (CLK),
		.RST_RESYNC  (RST_RESYNC),
		.wren_i      (wren_i),
		.wr_word_i   (wr_word),
		.ld_addr_i   (ld_addr),
		.strt_addr_i (strt_addr),
		.nxt_wrd_i   (nxt_wrd),
		.pending_i   (l1a_lvl != '0),
		.wr_addr_o   (wr_addr),
		.ring_amt_o  (ring_amt),
		.rd_word_o   (rdata_o),
		.data_push_o (data_push_o),
		.warn_o      (warn_o)
	);

	ring_trans_fsm ring_trans_fsm_i (
		.CLK           (CLK),
		.RST_RESYNC    (RST_RESYNC),
		.l1a_buf_mt_i  (l1a_buf_mt),
		.evt_buf_afl_i (evt_buf_afl_i),
		.ring_amt_i    (ring_amt),
		.samp_max_i    (samp_max_i),
		.ld_addr_o     (ld_addr),
		.nxt_wrd_o     (nxt_wrd)
	);

endmodule

`default_nettype wire

//--- bench/ringbuf_properties.sv
`default_nettype none

module ringbuf_properties (
	input wire CLK,
	input wire RST_RESYNC,
	input wire hdr_push_i,
	input wire data_push_i,
	input wire warn_i
);

	timeunit 1ns;
	timeprecision 1ps;

	int fail_cnt = 0;    // Failed property count

	hdr_single: assert property (@(posedge CLK) disable iff (RST_RESYNC)
		hdr_push_i |=> !hdr_push_i)
		else begin
			fail_cnt++;
			$error("Event header pulse held longer than one cycle");
		end

	rst_quiet: assert property (@(posedge CLK)
		RST_RESYNC |-> (!hdr_push_i && !data_push_i && !warn_i))
		else begin
			fail_cnt++;
			$error("Output strobe or warning active during reset");
		end

	// Previous event's words leave before the next header
	hdr_after_data: assert property (@(posedge CLK) disable iff (RST_RESYNC)
		data_push_i |-> (!hdr_push_i ##1 !hdr_push_i))
		else begin
			fail_cnt++;
			$error("Event header within two cycles of a data word");
		end

endmodule

bind ringbuf_top ringbuf_properties props0 (
	.CLK         (CLK),
	.RST_RESYNC  (RST_RESYNC),
	.hdr_push_i  (l1a_evt_push_o),
	.data_push_i (data_push_o),
	.warn_i      (warn_o)
);

`default_nettype wire

//--- bench/ringbuf_tb.sv
`default_nettype none

`include "ringbuf_defs.svh"

module ringbuf_tb;

	timeunit 1ns;
	timeprecision 1ps;

	import ring_data_pkg::*;
	import readout_ctrl_pkg::*;

	localparam int CLK_PERIOD = 8;
	localparam int RST_CYCLES = 16;
	localparam int NUM_ROWS   = 10;
	localparam int SETTLE     = 20;    // Quiet cycles after an event drains
	localparam int AFL_DELAY  = 12;    // Lands the almost-full window mid-event
	localparam int WARN_EARLY = `RING_WARN_LEVEL - 4;    // Just under the warning level

	typedef struct packed {
		logic [12:0] pre;      // Writes before the L1A, or distance below ring end
		logic        to_end;
		logic        match;
		logic        phase;
		logic [11:0] mcnt;
		logic [23:0] cnt;
		logic [6:0]  samp;
		logic [12:0] hold;     // Almost-full cycles
		logic        fill;     // Almost full from the L1A on
		logic        drain;
	} row_t;

	logic        CLK;
	logic        RST_RESYNC;
	logic        fifo_rst_i;
	samp_cnt_t   samp_max_i;
	sample_t     wdata_i;
	logic        wren_i;
	logic [37:0] l1a_smp_data_i;
	logic [6:0]  ovrlp_smp_data_i;
	logic        l1a_wrt_en_i;
	logic        evt_buf_afl_i;
	evt_hdr_t    l1a_evt_data_o;
	logic        l1a_evt_push_o;
	ring_word_t  rdata_o;
	logic        data_push_o;
	logic        warn_o;

	row_t        rows [0:NUM_ROWS-1];
	ring_word_t  model_mem [0:`RING_DEPTH-1];
	ring_addr_t  model_wr;
	evt_hdr_t    exp_hdr [$];
	ring_addr_t  exp_start [$];
	int          exp_len [$];
	ring_addr_t  rd_ptr;
	int          words_left;
	int          hdr_seen;
	int          afl_run;
	int          chk_cnt;
	int          err_cnt;
	int          prop_fails;
	int          cycle_cnt;
	int          cycle_limit;
	logic [31:0] lcg_state;
	logic        writing;

	ringbuf_top dut0 (
		.CLK              (CLK),
		.RST_RESYNC       (RST_RESYNC),
		.fifo_rst_i       (fifo_rst_i),
		.samp_max_i       (samp_max_i),
		.wdata_i          (wdata_i),
		.wren_i           (wren_i),
		.l1a_smp_data_i   (l1a_smp_data_i),
		.ovrlp_smp_data_i (ovrlp_smp_data_i),
		.l1a_wrt_en_i     (l1a_wrt_en_i),
		.evt_buf_afl_i    (evt_buf_afl_i),
		.l1a_evt_data_o   (l1a_evt_data_o),
		.l1a_evt_push_o   (l1a_evt_push_o),
		.rdata_o          (rdata_o),
		.data_push_o      (data_push_o),
		.warn_o           (warn_o)
	);

	always #(CLK_PERIOD/2) CLK = ~CLK;

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic load_table();
		//          pre       to_end match phase mcnt     cnt          samp   hold       fill  drain
		rows[0] = '{13'd20,   1'b0, 1'b1, 1'b0, 12'h001, 24'h000101, 7'd8,  13'd0,    1'b0, 1'b1};
		rows[1] = '{13'd5,    1'b0, 1'b0, 1'b1, 12'h0ff, 24'h000102, 7'd8,  13'd0,    1'b0, 1'b1};
		rows[2] = '{13'd10,   1'b0, 1'b1, 1'b1, 12'h002, 24'h000103, 7'd5,  13'd0,    1'b0, 1'b0};
		rows[3] = '{13'd0,    1'b0, 1'b1, 1'b0, 12'h003, 24'h000104, 7'd5,  13'd0,    1'b0, 1'b0};
		rows[4] = '{13'd0,    1'b0, 1'b1, 1'b1, 12'h004, 24'h000105, 7'd5,  13'd0,    1'b0, 1'b0};
		rows[5] = '{13'd1,    1'b0, 1'b1, 1'b0, 12'h005, 24'h000106, 7'd5,  13'd0,    1'b0, 1'b1};
		rows[6] = '{13'd12,   1'b0, 1'b1, 1'b1, 12'h006, 24'h000107, 7'd20, 13'd10,   1'b0, 1'b1};
		rows[7] = '{13'd8,    1'b0, 1'b1, 1'b0, 12'h007, 24'habcdef, 7'd0,  13'd0,    1'b0, 1'b1};
		rows[8] = '{13'd3,    1'b0, 1'b1, 1'b1, 12'h008, 24'h000109, 7'd16, 13'd3400, 1'b1, 1'b1};
		rows[9] = '{13'd4,    1'b1, 1'b1, 1'b0, 12'hfff, 24'hffffff, 7'd10, 13'd0,    1'b0, 1'b1};
	endtask

	function automatic int budget_total();
		int sum;
		sum = RST_CYCLES + 4;
		for (int i = 0; i < NUM_ROWS; i++) begin
			sum += rows[i].to_end ? `RING_DEPTH : int'(rows[i].pre);
			sum += int'(rows[i].hold) + int'(rows[i].samp) + AFL_DELAY + SETTLE + 30;
		end
		return 2 * sum;
	endfunction

	function automatic int matched_rows();
		int n;
		n = 0;
		for (int i = 0; i < NUM_ROWS; i++) begin
			n += rows[i].match ? 1 : 0;
		end
		return n;
	endfunction

	task automatic check_vec(input string name, input logic [63:0] got, input logic [63:0] exp);
		chk_cnt++;
		assert (got === exp) else begin
			err_cnt++;
			$display("[FAIL] %0t ns %s: got %0h, expected %0h", $time, name, got, exp);
		end
	endtask

	task automatic check_header();
		evt_hdr_t hdr;
		hdr_seen++;
		chk_cnt++;
		assert (words_left == 0) else begin
			err_cnt++;
			$display("Header at %0t ns came with %0d words of the last event missing",
				$time, words_left);
		end
		chk_cnt++;
		assert (exp_hdr.size() != 0) else begin
			err_cnt++;
			$display("Header at %0t ns with no matched L1A waiting", $time);
		end
		if (exp_hdr.size() != 0) begin
			hdr = exp_hdr.pop_front();
			check_vec("l1a_evt_data_o", l1a_evt_data_o, hdr);
			rd_ptr     = exp_start.pop_front();
			words_left = exp_len.pop_front();
		end
	endtask

	task automatic check_word();
		chk_cnt++;
		assert (words_left > 0) else begin
			err_cnt++;
			$display("Data word at %0t ns outside any event", $time);
		end
		if (words_left > 0) begin
			check_vec("rdata_o", rdata_o, model_mem[rd_ptr]);
			rd_ptr = rd_ptr + 1'b1;    // Wraps with the ring
			words_left--;
		end
	endtask

	task automatic apply_row(input row_t r);
		int n;
		n = r.to_end ? int'(ring_addr_t'(`RING_DEPTH - r.pre - model_wr)) : int'(r.pre);
		samp_max_i = r.samp;
		repeat (n) @(negedge CLK);
		l1a_smp_data_i = {r.phase, r.match, r.mcnt, r.cnt};
		l1a_wrt_en_i   = 1'b1;
		if (r.fill) begin
			evt_buf_afl_i = 1'b1;
		end
		@(negedge CLK);
		l1a_wrt_en_i = 1'b0;
		if (r.hold != 0) begin
			if (!r.fill) begin
				repeat (AFL_DELAY) @(negedge CLK);
			end
			evt_buf_afl_i = 1'b1;
			if (r.fill) begin
				repeat (WARN_EARLY) @(negedge CLK);
				check_vec("warn_o", warn_o, 1'b0);    // Pending but still under the level
				repeat (int'(r.hold) - WARN_EARLY) @(negedge CLK);
				check_vec("warn_o", warn_o, 1'b1);
			end else begin
				repeat (r.hold) @(negedge CLK);
			end
			evt_buf_afl_i = 1'b0;
		end
		if (r.drain) begin
			while (exp_hdr.size() != 0 || words_left != 0) begin
				@(negedge CLK);
			end
			repeat (SETTLE) @(negedge CLK);
			if (r.fill) begin
				check_vec("warn_o", warn_o, 1'b0);    // Nothing pending any more
			end
		end
	endtask

	// Sample writer puts one word in every cycle
	always @(negedge CLK) begin
		if (writing) begin
			lcg_state        = lcg_next(lcg_state);
			wren_i           = 1'b1;
			wdata_i          = lcg_state[27:16];
			ovrlp_smp_data_i = lcg_state[14:8];
		end
	end

	// Reference model of ring contents and accepted L1As
	always @(posedge CLK) begin
		if (wren_i) begin
			model_mem[model_wr] = {ovrlp_smp_data_i[5], ovrlp_smp_data_i[4],
				ovrlp_smp_data_i[3:0], wdata_i};
		end
		if (l1a_wrt_en_i && l1a_smp_data_i[36]) begin
			exp_hdr.push_back({l1a_smp_data_i[37], l1a_smp_data_i[35:0]});
			exp_start.push_back(model_wr);
			exp_len.push_back(int'(samp_max_i));
		end
		if (wren_i) begin
			model_wr = model_wr + 1'b1;
		end
	end

	// Output monitor samples a quarter period after the falling edge
	always @(negedge CLK) begin
		#(CLK_PERIOD/4);
		afl_run = evt_buf_afl_i ? afl_run + 1 : 0;
		if (afl_run > 2) begin
			chk_cnt++;
			assert (!data_push_o && !l1a_evt_push_o) else begin
				err_cnt++;
				$display("Output activity %0d cycles into almost full at %0t ns",
					afl_run, $time);
			end
		end
		if (data_push_o) begin
			check_word();
		end
		if (l1a_evt_push_o) begin
			check_header();
		end
	end

	always @(posedge CLK) begin
		cycle_cnt++;
		if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
			$display("Run stopped at the limit of %0d cycles with events outstanding",
				cycle_limit);
			$display("TB FAILED");
			$finish;
		end
	end

	initial begin
		CLK              = 1'b0;
		RST_RESYNC       = 1'b1;
		fifo_rst_i       = 1'b0;
		samp_max_i       = '0;
		wdata_i          = '0;
		wren_i           = 1'b0;
		l1a_smp_data_i   = '0;
		ovrlp_smp_data_i = '0;
		l1a_wrt_en_i     = 1'b0;
		evt_buf_afl_i    = 1'b0;
		writing          = 1'b0;
		lcg_state        = 32'd40499;
		model_wr         = '0;
		rd_ptr           = '0;
		words_left       = 0;
		hdr_seen         = 0;
		afl_run          = 0;
		chk_cnt          = 0;
		err_cnt          = 0;
		cycle_cnt        = 0;
		load_table();
		cycle_limit = budget_total();
		repeat (RST_CYCLES) @(negedge CLK);
		RST_RESYNC = 1'b0;
		@(posedge CLK);
		writing = 1'b1;
		@(negedge CLK);
		check_vec("warn_o", warn_o, 1'b0);
		check_vec("l1a_evt_push_o", l1a_evt_push_o, 1'b0);
		check_vec("data_push_o", data_push_o, 1'b0);
		for (int i = 0; i < NUM_ROWS; i++) begin
			apply_row(rows[i]);
		end
		check_vec("event header count", hdr_seen, matched_rows());
		prop_fails = dut0.props0.fail_cnt;
		$display("Checks: %0d, check errors: %0d, assertion failures: %0d",
			chk_cnt, err_cnt, prop_fails);
		if (err_cnt == 0 && prop_fails == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- files.f
+incdir+include
verilog/ring_data_pkg.sv
verilog/readout_ctrl_pkg.sv
verilog/l1a_fifo.sv
verilog/sample_ring.sv
verilog/ring_trans_fsm.sv
verilog/ringbuf_top.sv
bench/ringbuf_properties.sv
bench/ringbuf_tb.sv

//--- Bender.yml
package:
  name: ringbuf

sources:
  - include_dirs:
      - include
    files:
      - verilog/ring_data_pkg.sv
      - verilog/readout_ctrl_pkg.sv
      - verilog/l1a_fifo.sv
      - verilog/sample_ring.sv
      - verilog/ring_trans_fsm.sv
      - verilog/ringbuf_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - bench/ringbuf_properties.sv
      - bench/ringbuf_tb.sv
